//--- Bender.yml
package:
  name: mipsPipe

sources:
  - source/pipePkg.sv
  - source/instrIntake.sv
  - source/decodeStage.sv
  - source/executeStage.sv
  - source/memWbStage.sv
  - source/mipsPipe.sv
  - target: simulation
    files:
      - tb/mipsPipeTb.sv

//--- mipsPipe.f
source/pipePkg.sv
source/instrIntake.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/mipsPipe.sv
tb/mipsPipeTb.sv

//--- source/decodeStage.sv
// Decode stage with register file and ID/EX register; undefined encodings retire as no-operations
`timescale 1ns/1ns

module decodeStage (
	input logic sysclk,
	input logic reset,
	input logic idValid,
	input pipePkg::instrWord idInstr,
	input logic wbRegWrite,
	input logic [pipePkg::regAddrWidth-1:0] wbDest,
	input logic [pipePkg::dataWidth-1:0] wbData,
	output logic stall,
	output logic exValid,
	output logic [2:0] aluOp,
	output logic useImm,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic [pipePkg::regAddrWidth-1:0] destReg,
	output logic [pipePkg::regAddrWidth-1:0] rsAddr,
	output logic [pipePkg::regAddrWidth-1:0] rtAddr,
	output logic [pipePkg::dataWidth-1:0] rsData,
	output logic [pipePkg::dataWidth-1:0] rtData,
	output logic [pipePkg::dataWidth-1:0] immExt
);

	logic [pipePkg::dataWidth-1:0] regFile [0:(1 << pipePkg::regAddrWidth)-1];

	logic legal;
	logic readsRt;
	logic writesReg;
	logic decUseImm;
	logic decMemRead;
	logic decMemWrite;
	logic decRegWrite;
	logic [2:0] decAluOp;
	logic [pipePkg::regAddrWidth-1:0] decDest;
	logic [pipePkg::regAddrWidth-1:0] srcRs;
	logic [pipePkg::regAddrWidth-1:0] srcRt;
	logic [pipePkg::dataWidth-1:0] rsRead;
	logic [pipePkg::dataWidth-1:0] rtRead;
	logic take;

	// Control decode, I-type fields are the default view
	always_comb begin
		legal = 1'b1;
		readsRt = 1'b0;
		writesReg = 1'b1;
		decUseImm = 1'b1;
		decMemRead = 1'b0;
		decMemWrite = 1'b0;
		decAluOp = pipePkg::aluAdd;
		decDest = idInstr.iType.rt;
		case (idInstr.rType.opcode)
			pipePkg::opRType: begin
				decUseImm = 1'b0;
				readsRt = 1'b1;
				decDest = idInstr.rType.rd;
				case (idInstr.rType.funct)
					pipePkg::fnAdd: decAluOp = pipePkg::aluAdd;
					pipePkg::fnSub: decAluOp = pipePkg::aluSub;
					pipePkg::fnAnd: decAluOp = pipePkg::aluAnd;
					pipePkg::fnOr: decAluOp = pipePkg::aluOr;
					pipePkg::fnSlt: decAluOp = pipePkg::aluSlt;
					default: legal = 1'b0;
				endcase
			end
			pipePkg::opAddi: decAluOp = pipePkg::aluAdd;
			pipePkg::opLw: decMemRead = 1'b1;
			pipePkg::opSw: begin
				decMemWrite = 1'b1;
				readsRt = 1'b1;
				writesReg = 1'b0;
			end
			default: legal = 1'b0;
		endcase
	end

	// Unused sources read as register 0 so they never match a producer
	assign srcRs = legal ? idInstr.rType.rs : '0;
	assign srcRt = (legal && readsRt) ? idInstr.rType.rt : '0;
	// Writes to register 0 are dropped here
	assign decRegWrite = legal && writesReg && (decDest != '0);

	// Load in ID/EX feeding this instruction
	assign stall = idValid && exValid && memRead && regWrite &&
		((srcRs == destReg) || (srcRt == destReg));
	assign take = idValid && legal && !stall;

	// Write-through read ports
	assign rsRead = (wbRegWrite && (wbDest == srcRs)) ? wbData : regFile[srcRs];
	assign rtRead = (wbRegWrite && (wbDest == srcRt)) ? wbData : regFile[srcRt];

	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < (1 << pipePkg::regAddrWidth); i++) begin
				regFile[i] <= '0;
			end
		end else if (wbRegWrite) begin
			regFile[wbDest] <= wbData;
		end
	end

	// ID/EX control, a bubble on stall or invalid slot
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			exValid <= 1'b0;
			aluOp <= pipePkg::aluAdd;
			useImm <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			exValid <= take;
			aluOp <= decAluOp;
			useImm <= decUseImm;
			regWrite <= take && decRegWrite;
			memRead <= take && decMemRead;
			memWrite <= take && decMemWrite;
		end
	end

	// ID/EX payload
	always_ff @(posedge sysclk) begin
		destReg <= decDest;
		rsAddr <= srcRs;
		rtAddr <= srcRt;
		rsData <= rsRead;
		rtData <= rtRead;
		immExt <= {{(pipePkg::dataWidth-16){idInstr.iType.imm[15]}}, idInstr.iType.imm};
	end

	// Writeback never targets register 0
	noZeroWrite: assert property (
		@(posedge sysclk) disable iff (!reset)
		wbRegWrite |-> (wbDest != '0)
	);

	loadStoreExclusive: assert property (
		@(posedge sysclk) disable iff (!reset)
		!(memRead && memWrite)
	);

endmodule

//--- source/executeStage.sv
// Execute stage with forwarding and EX/MEM register; slt compares signed, no overflow trap
`timescale 1ns/1ns

module executeStage (
	input logic sysclk,
	input logic reset,
	input logic exValid,
	input logic [2:0] aluOp,
	input logic useImm,
	input logic regWrite,
	input logic exMemRead,
	input logic exMemWrite,
	input logic [pipePkg::regAddrWidth-1:0] destReg,
	input logic [pipePkg::regAddrWidth-1:0] rsAddr,
	input logic [pipePkg::regAddrWidth-1:0] rtAddr,
	input logic [pipePkg::dataWidth-1:0] rsData,
	input logic [pipePkg::dataWidth-1:0] rtData,
	input logic [pipePkg::dataWidth-1:0] immExt,
	input logic wbRegWrite,
	input logic [pipePkg::regAddrWidth-1:0] wbDest,
	input logic [pipePkg::dataWidth-1:0] wbData,
	output logic memValid,
	output logic memRegWrite,
	output logic memRead,
	output logic memWrite,
	output logic [pipePkg::regAddrWidth-1:0] memDest,
	output logic [pipePkg::dataWidth-1:0] aluResult,
	output logic [pipePkg::dataWidth-1:0] storeData
);

	logic [1:0] rsSel;
	logic [1:0] rtSel;
	logic [pipePkg::dataWidth-1:0] opA;
	logic [pipePkg::dataWidth-1:0] rtVal;
	logic [pipePkg::dataWidth-1:0] opB;
	logic [pipePkg::dataWidth-1:0] aluOut;

	// Newer producer in EX/MEM wins over MEM/WB
	function automatic logic [1:0] pickFwd(input logic [pipePkg::regAddrWidth-1:0] src);
		logic [1:0] sel;
		sel = pipePkg::fwdNone;
		if (src != '0) begin
			if (memRegWrite && (memDest == src)) begin
				sel = pipePkg::fwdMem;
			end else if (wbRegWrite && (wbDest == src)) begin
				sel = pipePkg::fwdWb;
			end
		end
		return sel;
	endfunction

	function automatic logic [pipePkg::dataWidth-1:0] fwdValue(
		input logic [1:0] sel,
		input logic [pipePkg::dataWidth-1:0] regVal
	);
		case (sel)
			pipePkg::fwdMem: return aluResult;
			pipePkg::fwdWb: return wbData;
			default: return regVal;
		endcase
	endfunction

	// Operand selection, also follows the forwarding registers read inside the functions
	always_comb begin
		rsSel = pickFwd(rsAddr);
		rtSel = pickFwd(rtAddr);
		opA = fwdValue(rsSel, rsData);
		rtVal = fwdValue(rtSel, rtData);
	end

	assign opB = useImm ? immExt : rtVal;

	always_comb begin
		case (aluOp)
			pipePkg::aluSub: aluOut = opA - opB;
			pipePkg::aluAnd: aluOut = opA & opB;
			pipePkg::aluOr: aluOut = opA | opB;
			pipePkg::aluSlt: aluOut = ($signed(opA) < $signed(opB)) ? 1 : 0;
			default: aluOut = opA + opB;
		endcase
	end

	// EX/MEM control
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			memValid <= 1'b0;
			memRegWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			memValid <= exValid;
			memRegWrite <= regWrite;
			memRead <= exMemRead;
			memWrite <= exMemWrite;
		end
	end

	// EX/MEM payload
	always_ff @(posedge sysclk) begin
		memDest <= destReg;
		aluResult <= aluOut;
		storeData <= rtVal;
	end

	// The load-use stall in decode keeps loads out of the EX/MEM path
	noLoadForward: assert property (
		@(posedge sysclk) disable iff (!reset)
		exValid && (rsSel == pipePkg::fwdMem || rtSel == pipePkg::fwdMem) |-> !memRead
	);

endmodule

//--- source/instrIntake.sv
// Input side of the pipeline; the source must hold inValid and inInstr until inReady is seen high
`timescale 1ns/1ns

module instrIntake (
	input logic sysclk,
	input logic reset,
	input logic inValid,
	input pipePkg::instrWord inInstr,
	input logic stall,
	output logic inReady,
	output logic idValid,
	output pipePkg::instrWord idInstr
);

	logic transfer;

	// Decode refuses new words only for the load-use bubble
	assign inReady = !stall;
	assign transfer = inValid && inReady;

	// Valid bit of the IF/ID register
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			idValid <= 1'b0;
		end else if (stall) begin
			idValid <= idValid;
		end else begin
			idValid <= transfer;
		end
	end

	// Instruction word, held during a stall
	always_ff @(posedge sysclk) begin
		if (transfer) begin
			idInstr <= inInstr;
		end
	end

	// Source keeps its word while it waits for a transfer
	holdWhileWaiting: assert property (
		@(posedge sysclk) disable iff (!reset)
		inValid && !inReady |=> $stable(inInstr)
	);

endmodule

//--- source/memWbStage.sv
// Memory and writeback stage; 64-word data memory, address bits above 7 are ignored
`timescale 1ns/1ns

module memWbStage (
	input logic sysclk,
	input logic reset,
	input logic memValid,
	input logic memRegWrite,
	input logic memRead,
	input logic memWrite,
	input logic [pipePkg::regAddrWidth-1:0] memDest,
	input logic [pipePkg::dataWidth-1:0] aluResult,
	input logic [pipePkg::dataWidth-1:0] storeData,
	output logic wbRegWrite,
	output logic [pipePkg::regAddrWidth-1:0] wbDest,
	output logic [pipePkg::dataWidth-1:0] wbData,
	output logic commitValid,
	output logic [pipePkg::regAddrWidth-1:0] commitReg,
	output logic [pipePkg::dataWidth-1:0] commitData
);

	logic [pipePkg::dataWidth-1:0] dataMem [0:(1 << pipePkg::dmemAddrWidth)-1];
	logic [pipePkg::dmemAddrWidth-1:0] wordAddr;
	logic [pipePkg::dataWidth-1:0] readWord;

	// Word index from the byte address
	assign wordAddr = aluResult[pipePkg::dmemAddrWidth+1:2];
	assign readWord = dataMem[wordAddr];

	// Store lands at the same edge as the MEM/WB load
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < (1 << pipePkg::dmemAddrWidth); i++) begin
				dataMem[i] <= '0;
			end
		end else if (memValid && memWrite) begin
			dataMem[wordAddr] <= storeData;
		end
	end

	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			wbRegWrite <= 1'b0;
		end else begin
			wbRegWrite <= memValid && memRegWrite;
		end
	end

	// Loads take the memory word, everything else the ALU result
	always_ff @(posedge sysclk) begin
		wbDest <= memDest;
		wbData <= memRead ? readWord : aluResult;
	end

	// Commit mirrors the register file write
	assign commitValid = wbRegWrite;
	assign commitReg = wbDest;
	assign commitData = wbData;

endmodule

//--- source/mipsPipe.sv
// Pipeline top; input back-pressure only, commits have no ready and must be taken when valid
`timescale 1ns/1ns

module mipsPipe (
	input logic sysclk,
	input logic reset,
	input logic inValid,
	input pipePkg::instrWord inInstr,
	output logic inReady,
	output logic commitValid,
	output logic [pipePkg::regAddrWidth-1:0] commitReg,
	output logic [pipePkg::dataWidth-1:0] commitData
);

	logic stall;
	logic idValid;
	pipePkg::instrWord idInstr;

	// ID/EX
	logic exValid;
	logic [2:0] aluOp;
	logic useImm;
	logic regWrite;
	logic exMemRead;
	logic exMemWrite;
	logic [pipePkg::regAddrWidth-1:0] destReg;
	logic [pipePkg::regAddrWidth-1:0] rsAddr;
	logic [pipePkg::regAddrWidth-1:0] rtAddr;
	logic [pipePkg::dataWidth-1:0] rsData;
	logic [pipePkg::dataWidth-1:0] rtData;
	logic [pipePkg::dataWidth-1:0] immExt;

	// EX/MEM
	logic memValid;
	logic memRegWrite;
	logic memRead;
	logic memWrite;
	logic [pipePkg::regAddrWidth-1:0] memDest;
	logic [pipePkg::dataWidth-1:0] aluResult;
	logic [pipePkg::dataWidth-1:0] storeData;

	// MEM/WB
	logic wbRegWrite;
	logic [pipePkg::regAddrWidth-1:0] wbDest;
	logic [pipePkg::dataWidth-1:0] wbData;

	instrIntake i_intake (
		.sysclk(sysclk),
		.reset(reset),
		.inValid(inValid),
		.inInstr(inInstr),
		.stall(stall),
		.inReady(inReady),
		.idValid(idValid),
		.idInstr(idInstr)
	);

	decodeStage i_decode (
		.sysclk(sysclk),
		.reset(reset),
		.idValid(idValid),
		.idInstr(idInstr),
		.wbRegWrite(wbRegWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.stall(stall),
		.exValid(exValid),
		.aluOp(aluOp),
		.useImm(useImm),
		.regWrite(regWrite),
		.memRead(exMemRead),
		.memWrite(exMemWrite),
		.destReg(destReg),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.immExt(immExt)
	);

	executeStage i_execute (
		.sysclk(sysclk),
		.reset(reset),
		.exValid(exValid),
		.aluOp(aluOp),
		.useImm(useImm),
		.regWrite(regWrite),
		.exMemRead(exMemRead),
		.exMemWrite(exMemWrite),
		.destReg(destReg),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.immExt(immExt),
		.wbRegWrite(wbRegWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.memValid(memValid),
		.memRegWrite(memRegWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.memDest(memDest),
		.aluResult(aluResult),
		.storeData(storeData)
	);

	memWbStage i_memWb (
		.sysclk(sysclk),
		.reset(reset),
		.memValid(memValid),
		.memRegWrite(memRegWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.memDest(memDest),
		.aluResult(aluResult),
		.storeData(storeData),
		.wbRegWrite(wbRegWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.commitValid(commitValid),
		.commitReg(commitReg),
		.commitData(commitData)
	);

endmodule

//--- source/pipePkg.sv
// Shared definitions of the pipeline; word-addressed data memory of 64 words, no byte access
package pipePkg;

	// Data path sizes
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	// 64 data words, word index taken from byte address bits 7:2
	localparam int dmemAddrWidth = 6;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'd0;
	localparam logic [5:0] opAddi = 6'd8;
	localparam logic [5:0] opLw = 6'd35;
	localparam logic [5:0] opSw = 6'd43;

	// Function field of R-type
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnSlt = 6'd42;

	// ALU operations
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr = 3'd3;
	localparam logic [2:0] aluSlt = 3'd4;

	// Operand source in execute
	localparam logic [1:0] fwdNone = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

	// One instruction word, seen as R-type or I-type layout
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

endpackage

//--- tb/mipsPipeTb.sv
// Random self-checking testbench; fixed seed, registers 0 to 7 only, stops at the first mismatch
`timescale 1ns/1ns

module mipsPipeTb;

	localparam int numInstr = 400;
	localparam int watchdogNs = (numInstr * 3 + 100) * 8;

	logic sysclk;
	logic reset;
	logic inValid;
	pipePkg::instrWord inInstr;
	logic inReady;
	logic commitValid;
	logic [pipePkg::regAddrWidth-1:0] commitReg;
	logic [pipePkg::dataWidth-1:0] commitData;

	integer seed;
	int edgeCount = 0;
	int stallCycles = 0;
	int predictedStalls = 0;
	int commitsSeen = 0;
	int commitsQueued = 0;
	int sent;
	int prevExEdge = -10;
	logic [pipePkg::regAddrWidth-1:0] prevLoadDest = '0;
	logic taken;

	// Architectural state of the reference model
	logic [pipePkg::dataWidth-1:0] modelRegs [32];
	logic [pipePkg::dataWidth-1:0] modelMem [64];

	// Expected commits in program order
	logic [pipePkg::regAddrWidth-1:0] expReg [$];
	logic [pipePkg::dataWidth-1:0] expData [$];
	int expEdge [$];

	mipsPipe i_dut (
		.sysclk(sysclk),
		.reset(reset),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.commitValid(commitValid),
		.commitReg(commitReg),
		.commitData(commitData)
	);

	always #4 sysclk = ~sysclk;

	always @(posedge sysclk) edgeCount++;

	task automatic reportError(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			reportError($sformatf("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic checkReg(input string name, input logic [pipePkg::regAddrWidth-1:0] got,
		input logic [pipePkg::regAddrWidth-1:0] exp);
		if (got !== exp) begin
			reportError($sformatf("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic checkData(input string name, input logic [pipePkg::dataWidth-1:0] got,
		input logic [pipePkg::dataWidth-1:0] exp);
		if (got !== exp) begin
			reportError($sformatf("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			reportError($sformatf("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	function automatic logic [pipePkg::regAddrWidth-1:0] pickReg();
		return $random(seed) & 7;
	endfunction

	// Weighted mix, undefined opcodes about one in sixteen
	function automatic pipePkg::instrWord nextInstr();
		pipePkg::instrWord w;
		int kind;
		logic [5:0] op;
		kind = $random(seed) & 31;
		w = $random(seed);
		if (kind < 2) begin
			op = $random(seed);
			if (op == pipePkg::opRType || op == pipePkg::opAddi || op == pipePkg::opLw ||
				op == pipePkg::opSw) begin
				op = 6'h3f;
			end
			w.iType.opcode = op;
		end else if (kind < 14) begin
			w.rType.opcode = pipePkg::opRType;
			w.rType.rs = pickReg();
			w.rType.rt = pickReg();
			w.rType.rd = pickReg();
			w.rType.shamt = '0;
			case ($unsigned($random(seed)) % 5)
				0: w.rType.funct = pipePkg::fnAdd;
				1: w.rType.funct = pipePkg::fnSub;
				2: w.rType.funct = pipePkg::fnAnd;
				3: w.rType.funct = pipePkg::fnOr;
				default: w.rType.funct = pipePkg::fnSlt;
			endcase
		end else begin
			w.iType.opcode = (kind < 20) ? pipePkg::opAddi :
				(kind < 26) ? pipePkg::opLw : pipePkg::opSw;
			w.iType.rs = pickReg();
			w.iType.rt = pickReg();
			// Memory ops get a word offset, addi keeps the full random immediate
			if (kind >= 20) begin
				w.iType.imm = {8'd0, 6'($random(seed)), 2'b00};
			end
		end
		return w;
	endfunction

	// Executes one accepted word and predicts its stall and commit edge
	task automatic modelStep(input pipePkg::instrWord w, input int acceptEdge);
		logic [pipePkg::dataWidth-1:0] a;
		logic [pipePkg::dataWidth-1:0] b;
		logic [pipePkg::dataWidth-1:0] imm;
		logic [pipePkg::dataWidth-1:0] res;
		logic [pipePkg::regAddrWidth-1:0] dest;
		logic legal;
		logic writes;
		logic readsRt;
		logic isLoad;
		logic stallNow;
		int exEdge;
		a = modelRegs[w.iType.rs];
		b = modelRegs[w.iType.rt];
		imm = {{16{w.iType.imm[15]}}, w.iType.imm};
		res = '0;
		dest = w.iType.rt;
		legal = 1'b1;
		writes = 1'b1;
		readsRt = 1'b0;
		isLoad = 1'b0;
		case (w.iType.opcode)
			pipePkg::opRType: begin
				dest = w.rType.rd;
				readsRt = 1'b1;
				case (w.rType.funct)
					pipePkg::fnAdd: res = a + b;
					pipePkg::fnSub: res = a - b;
					pipePkg::fnAnd: res = a & b;
					pipePkg::fnOr: res = a | b;
					pipePkg::fnSlt: res = ($signed(a) < $signed(b)) ? 1 : 0;
					default: legal = 1'b0;
				endcase
			end
			pipePkg::opAddi: res = a + imm;
			pipePkg::opLw: begin
				res = modelMem[(a + imm) >> 2 & 63];
				isLoad = 1'b1;
			end
			pipePkg::opSw: begin
				modelMem[(a + imm) >> 2 & 63] = b;
				writes = 1'b0;
				readsRt = 1'b1;
			end
			default: legal = 1'b0;
		endcase
		// Load in EX while this word sits in decode
		stallNow = legal && (prevLoadDest != '0) && (prevExEdge == acceptEdge) &&
			((w.iType.rs == prevLoadDest) || (readsRt && w.iType.rt == prevLoadDest));
		exEdge = acceptEdge + 1 + int'(stallNow);
		predictedStalls += int'(stallNow);
		prevExEdge = exEdge;
		prevLoadDest = (legal && isLoad) ? w.iType.rt : '0;
		if (legal && writes && dest != '0) begin
			modelRegs[dest] = res;
			expReg.push_back(dest);
			expData.push_back(res);
			expEdge.push_back(exEdge + 2);
			commitsQueued++;
		end
	endtask

	always @(negedge sysclk) begin
		if (reset && !inReady) begin
			stallCycles++;
		end
	end

	// Commit monitor, outputs are stable at the falling edge
	always @(negedge sysclk) begin
		if (reset && commitValid) begin
			if (expReg.size() == 0) begin
				reportError("A commit appeared that no instruction should have produced");
			end else begin
				checkReg("commitReg", commitReg, expReg.pop_front());
				checkData("commitData", commitData, expData.pop_front());
				checkCount("commit edge", edgeCount, expEdge.pop_front());
				commitsSeen++;
			end
		end
	end

	initial begin
		#(watchdogNs);
		reportError("Watchdog expired before the pipeline drained");
	end

	initial begin
		seed = 32'ha2fb41fc;
		sysclk = 1'b0;
		reset = 1'b0;
		inValid = 1'b0;
		inInstr = '0;
		sent = 0;
		taken = 1'b0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			modelMem[i] = '0;
		end
		repeat (8) @(negedge sysclk);
		reset = 1'b1;
		// Quiet pipeline after reset
		repeat (6) begin
			@(negedge sysclk);
			checkBit("inReady", inReady, 1'b1);
			checkBit("commitValid", commitValid, 1'b0);
		end
		while (sent < numInstr) begin
			@(negedge sysclk);
			if (!inValid || taken) begin
				taken = 1'b0;
				if (($random(seed) & 3) == 0) begin
					inValid = 1'b0;
				end else begin
					inValid = 1'b1;
					inInstr = nextInstr();
				end
			end
			// Transfer happens at the coming rising edge
			if (inValid && inReady) begin
				modelStep(inInstr, edgeCount + 1);
				taken = 1'b1;
				sent++;
			end
		end
		@(negedge sysclk);
		inValid = 1'b0;
		while (expReg.size() != 0) begin
			@(negedge sysclk);
		end
		repeat (8) @(negedge sysclk);
		if (commitsSeen != commitsQueued) begin
			reportError($sformatf("Fail at %0t ns: commit count got %0d expected %0d",
				$time, commitsSeen, commitsQueued));
		end else if (stallCycles != predictedStalls) begin
			reportError($sformatf("Fail at %0t ns: stall cycles got %0d expected %0d",
				$time, stallCycles, predictedStalls));
		end else if (predictedStalls == 0) begin
			reportError("The random stream held no load-use pair, so no stall was exercised");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule
